// ==== design/rv_core_pkg.sv ====
package rv_core_pkg;

    localparam int xlen = 32;                      // data and address width
    localparam logic [xlen-1:0] reset_pc = 32'h0;  // address of the first fetch

    // opcode groups are opcode bits 6:4 followed by bit 2
    localparam logic [3:0] group_load   = 4'b0000;
    localparam logic [3:0] group_op_imm = 4'b0010;
    localparam logic [3:0] group_auipc  = 4'b0011;
    localparam logic [3:0] group_store  = 4'b0100;
    localparam logic [3:0] group_op     = 4'b0110;
    localparam logic [3:0] group_lui    = 4'b0111;
    localparam logic [3:0] group_branch = 4'b1100;

    localparam logic [1:0] opa_rs1  = 2'b00;  // operand A from the register bank
    localparam logic [1:0] opa_pc   = 2'b01;  // auipc adds to the pc
    localparam logic [1:0] opa_zero = 2'b10;  // lui ignores operand A

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } seq_state_e;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;  // also carries the B format bits 12 and 10:5
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;   // B format bits 4:1 and 11
            logic [6:0] opcode;
        } s;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } instr_u;

endpackage

// ==== design/main_controller.sv ====
`timescale 1ns/1ns

module main_controller (
    input  logic [6:0] opcode,
    input  logic       hazard_mux_enable,  // bubble from the sequencer
    output logic       branch,
    output logic       memory_read,
    output logic       memory_to_register,
    output logic [3:0] alu_option,
    output logic       memory_write,
    output logic       alu_source,         // high selects the immediate as operand B
    output logic       register_write,
    output logic [1:0] opa_sel
);
    import rv_core_pkg::*;

    logic [3:0] group;

    assign group      = {opcode[6:4], opcode[2]};
    assign alu_option = hazard_mux_enable ? 4'b0000 : group;

    always_comb begin
        branch             = 1'b0;
        memory_read        = 1'b0;
        memory_to_register = 1'b0;
        memory_write       = 1'b0;
        alu_source         = 1'b0;
        register_write     = 1'b0;
        opa_sel            = opa_rs1;
        if (!hazard_mux_enable) begin
            case (group)
                group_load: begin
                    alu_source         = 1'b1;
                    memory_read        = 1'b1;
                    memory_to_register = 1'b1;  // writeback takes the load data
                    register_write     = 1'b1;
                end
                group_op_imm: begin
                    alu_source     = 1'b1;
                    register_write = 1'b1;
                end
                group_auipc: begin
                    alu_source     = 1'b1;
                    register_write = 1'b1;
                    opa_sel        = opa_pc;
                end
                group_store: begin
                    alu_source   = 1'b1;  // address is rs1 plus the S immediate
                    memory_write = 1'b1;
                end
                group_op: begin
                    register_write = 1'b1;
                end
                group_lui: begin
                    alu_source     = 1'b1;
                    register_write = 1'b1;
                    opa_sel        = opa_zero;
                end
                group_branch: begin
                    branch = 1'b1;  // the ALU compares rs1 with rs2
                end
                default: ;  // opcodes outside the subset raise no strobe
            endcase
        end
    end

    // a request is either a read or a write, the data port has a single we bit
    mem_strobe_excl_a: assert final (!(memory_read && memory_write))
        else $error("memory_read and memory_write high together");

endmodule

// ==== design/core_sequencer.sv ====
`timescale 1ns/1ns

module core_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic memory_read,     // strobes as captured by the top level
    input  logic memory_write,
    input  logic register_write,
    input  logic branch,
    input  logic branch_taken,
    output logic bubble,
    output logic instr_req,
    output logic ir_load,
    output logic data_req,
    output logic data_we,
    output logic rf_we,
    output logic wb_valid,
    output logic pc_step,
    output logic pc_load
);
    import rv_core_pkg::*;

    seq_state_e state;
    seq_state_e state_next;
    logic       run_q;      // stays low until the first edge out of reset
    logic       wb_cycle;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_fetch;
            run_q <= 1'b0;
        end else begin
            state <= state_next;
            run_q <= 1'b1;
        end
    end

    always_comb begin
        case (state)
            st_fetch:     state_next = run_q ? st_decode : st_fetch;
            st_decode:    state_next = st_execute;
            st_execute:   state_next = (memory_read || memory_write) ? st_memory : st_writeback;
            st_memory:    state_next = st_writeback;  // data reply arrives here
            st_writeback: state_next = st_fetch;
            default:      state_next = st_fetch;
        endcase
    end

    assign wb_cycle  = (state == st_writeback);
    assign bubble    = !(state == st_decode || state == st_execute);
    assign instr_req = run_q && (state == st_fetch);
    assign ir_load   = (state == st_decode);  // instruction word is on instr_data now
    assign data_req  = (state == st_execute) && (memory_read || memory_write);
    assign data_we   = data_req && memory_write;
    assign rf_we     = wb_cycle && register_write;
    assign wb_valid  = wb_cycle && register_write;  // x0 writes are traced as well
    assign pc_load   = wb_cycle && branch && branch_taken;
    assign pc_step   = wb_cycle && !(branch && branch_taken);

    pc_update_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(pc_step && pc_load));

endmodule

// ==== design/program_counter.sv ====
`timescale 1ns/1ns

module program_counter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pc_step,
    input  logic                         pc_load,
    input  logic [rv_core_pkg::xlen-1:0] target,  // pc plus the B immediate
    output logic [rv_core_pkg::xlen-1:0] pc
);
    import rv_core_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (pc_load) begin
            pc <= target;  // taken branch
        end else if (pc_step) begin
            pc <= pc + xlen'(4);
        end
    end

    // the B immediate only guarantees halfword alignment, so a bad offset shows up here
    pc_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

// ==== design/register_bank.sv ====
`timescale 1ns/1ns

module register_bank (
    input  logic                         clk,
    input  logic [4:0]                   rs1,
    input  logic [4:0]                   rs2,
    input  logic [4:0]                   rd,
    input  logic                         we,
    input  logic [rv_core_pkg::xlen-1:0] wdata,
    output logic [rv_core_pkg::xlen-1:0] rdata1,
    output logic [rv_core_pkg::xlen-1:0] rdata2
);
    import rv_core_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && (rd != 5'd0)) begin
            regs[rd] <= wdata;  // x0 is never stored
        end
    end

    // reads are combinational, x0 is forced to zero
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== design/immediate_gen.sv ====
`timescale 1ns/1ns

module immediate_gen (
    input  rv_core_pkg::instr_u          instr,
    output logic [rv_core_pkg::xlen-1:0] imm
);
    import rv_core_pkg::*;

    logic [3:0] group;

    assign group = {instr.r.opcode[6:4], instr.r.opcode[2]};

    always_comb begin
        case (group)
            group_load, group_op_imm: begin
                imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            group_store: begin
                imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            end
            group_branch: begin
                // B format reuses the S fields, bit 11 sits in the low bit of imm_4_0
                imm = {{19{instr.s.imm_11_5[6]}}, instr.s.imm_11_5[6], instr.s.imm_4_0[0],
                       instr.s.imm_11_5[5:0], instr.s.imm_4_0[4:1], 1'b0};
            end
            group_lui, group_auipc: begin
                imm = {instr.u.imm_31_12, 12'b0};
            end
            default: begin
                imm = '0;  // R type has no immediate
            end
        endcase
    end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  logic [3:0]                   alu_option,  // opcode group from the controller
    input  logic [2:0]                   funct3,
    input  logic                         funct7_5,
    input  logic                         alu_source,
    input  logic [rv_core_pkg::xlen-1:0] a,
    input  logic [rv_core_pkg::xlen-1:0] rs2_value,
    input  logic [rv_core_pkg::xlen-1:0] imm,
    output logic [rv_core_pkg::xlen-1:0] result,
    output logic                         branch_taken
);
    import rv_core_pkg::*;

    alu_op_e         op;
    logic [xlen-1:0] b;

    assign b = alu_source ? imm : rs2_value;

    always_comb begin
        case (alu_option)
            group_op, group_op_imm: begin
                case (funct3)
                    3'b000:  op = (alu_option == group_op && funct7_5) ? op_sub : op_add;
                    3'b010:  op = op_slt;
                    3'b100:  op = op_xor;
                    3'b110:  op = op_or;
                    3'b111:  op = op_and;
                    default: op = op_add;  // shifts and sltu are outside the subset
                endcase
            end
            group_lui: op = op_pass_b;
            default:   op = op_add;  // load, store and auipc all form a sum
        endcase
    end

    always_comb begin
        case (op)
            op_add:    result = a + b;
            op_sub:    result = a - b;
            op_and:    result = a & b;
            op_or:     result = a | b;
            op_xor:    result = a ^ b;
            op_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            op_pass_b: result = b;
            default:   result = a + b;
        endcase
    end

    // the sequencer only acts on this when the captured branch strobe is set
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (a == rs2_value);
            3'b001:  branch_taken = (a != rs2_value);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== design/rv_core_top.sv ====
`timescale 1ns/1ns

module rv_core_top (
    input  logic                         clk,
    input  logic                         rst_n,
    output logic                         instr_req,
    output logic [rv_core_pkg::xlen-1:0] instr_addr,
    input  logic [31:0]                  instr_data,
    output logic                         data_req,
    output logic                         data_we,
    output logic [rv_core_pkg::xlen-1:0] data_addr,
    output logic [rv_core_pkg::xlen-1:0] data_wdata,
    input  logic [rv_core_pkg::xlen-1:0] data_rdata,
    output logic                         wb_valid,
    output logic [4:0]                   wb_rd,
    output logic [rv_core_pkg::xlen-1:0] wb_data
);
    import rv_core_pkg::*;

    instr_u          ir_q;
    instr_u          instr_cur;     // memory reply during decode, the IR afterwards
    logic            bubble;
    logic            ir_load;
    logic            rf_we;
    logic            pc_step;
    logic            pc_load;
    logic            branch;
    logic            memory_read;
    logic            memory_to_register;
    logic [3:0]      alu_option;
    logic            memory_write;
    logic            alu_source;
    logic            register_write;
    logic [1:0]      opa_sel;
    logic            branch_q;
    logic            memory_read_q;
    logic            memory_write_q;
    logic            memory_to_register_q;
    logic            register_write_q;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] target;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic [xlen-1:0] opa;
    logic [xlen-1:0] alu_result;
    logic            branch_taken;
    logic [xlen-1:0] alu_q;
    logic [xlen-1:0] load_q;
    logic [xlen-1:0] wdata;

    assign instr_cur = ir_load ? instr_data : ir_q;

    // strobes are steady through decode and execute, the last load is the one that counts
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            branch_q             <= 1'b0;
            memory_read_q        <= 1'b0;
            memory_write_q       <= 1'b0;
            memory_to_register_q <= 1'b0;
            register_write_q     <= 1'b0;
        end else if (!bubble) begin
            branch_q             <= branch;
            memory_read_q        <= memory_read;
            memory_write_q       <= memory_write;
            memory_to_register_q <= memory_to_register;
            register_write_q     <= register_write;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_load) begin
            ir_q <= instr_cur;
        end
        if (!bubble) begin
            alu_q <= alu_result;
        end
        if (memory_read_q) begin
            load_q <= data_rdata;  // the reply is on data_rdata in the memory state
        end
    end

    always_comb begin
        case (opa_sel)
            opa_pc:   opa = pc;
            opa_zero: opa = '0;
            default:  opa = rdata1;
        endcase
    end

    assign target     = pc + imm;
    assign wdata      = memory_to_register_q ? load_q : alu_q;
    assign instr_addr = pc;
    assign data_addr  = alu_result;  // valid in execute, when data_req is raised
    assign data_wdata = rdata2;
    assign wb_rd      = ir_q.r.rd;
    assign wb_data    = wdata;

    main_controller ctrl_i (
        .opcode             (instr_cur.r.opcode),
        .hazard_mux_enable  (bubble),
        .branch             (branch),
        .memory_read        (memory_read),
        .memory_to_register (memory_to_register),
        .alu_option         (alu_option),
        .memory_write       (memory_write),
        .alu_source         (alu_source),
        .register_write     (register_write),
        .opa_sel            (opa_sel)
    );

    core_sequencer seq_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .memory_read    (memory_read_q),
        .memory_write   (memory_write_q),
        .register_write (register_write_q),
        .branch         (branch_q),
        .branch_taken   (branch_taken),
        .bubble         (bubble),
        .instr_req      (instr_req),
        .ir_load        (ir_load),
        .data_req       (data_req),
        .data_we        (data_we),
        .rf_we          (rf_we),
        .wb_valid       (wb_valid),
        .pc_step        (pc_step),
        .pc_load        (pc_load)
    );

    program_counter pc_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc_step (pc_step),
        .pc_load (pc_load),
        .target  (target),
        .pc      (pc)
    );

    register_bank rf_i (
        .clk    (clk),
        .rs1    (instr_cur.r.rs1),
        .rs2    (instr_cur.r.rs2),
        .rd     (ir_q.r.rd),
        .we     (rf_we),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    immediate_gen imm_i (
        .instr (instr_cur),
        .imm   (imm)
    );

    alu alu_i (
        .alu_option   (alu_option),
        .funct3       (instr_cur.r.funct3),
        .funct7_5     (instr_cur.r.funct7[5]),
        .alu_source   (alu_source),
        .a            (opa),
        .rs2_value    (rdata2),
        .imm          (imm),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

endmodule

// ==== bench/iss_model.svh ====
`ifndef ISS_MODEL_SVH
`define ISS_MODEL_SVH

// architectural state of the reference, kept apart from the DUT and the bench memories
logic [31:0] ref_regs [32];
logic [31:0] ref_pc;
logic [31:0] ref_mem [256];

// what the last stepped instruction must show on the DUT ports
logic        exp_wb = 1'b0;
logic [4:0]  exp_rd;
logic [31:0] exp_value;
logic        exp_mem = 1'b0;
logic        exp_we;
logic [31:0] exp_addr;
logic [31:0] exp_store;

int beq_taken = 0;  // branch mix seen in execution order
int beq_fall  = 0;
int bne_taken = 0;
int bne_fall  = 0;

// RV32I arithmetic for addi/add/sub, slti/slt, xor, or and and
function automatic logic [31:0] arith_result(input logic [2:0] f3, input logic negate,
                                             input logic [31:0] x, input logic [31:0] y);
    case (f3)
        3'b000:  return negate ? x - y : x + y;
        3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        3'b100:  return x ^ y;
        3'b110:  return x | y;
        3'b111:  return x & y;
        default: return 32'd0;  // never generated
    endcase
endfunction

task automatic step_reference(input logic [31:0] word);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic        taken;
    rd     = word[11:7];
    rs1    = word[19:15];
    rs2    = word[24:20];
    f3     = word[14:12];
    a      = ref_regs[rs1];  // x0 is never written, so it reads as zero
    b      = ref_regs[rs2];
    imm_i  = {{20{word[31]}}, word[31:20]};
    imm_s  = {{20{word[31]}}, word[31:25], word[11:7]};
    imm_b  = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    exp_rd = rd;
    exp_wb = 1'b0;
    exp_mem = 1'b0;
    exp_we = 1'b0;
    case (word[6:0])
        opc_lui: begin
            exp_wb    = 1'b1;
            exp_value = {word[31:12], 12'b0};
        end
        opc_auipc: begin
            exp_wb    = 1'b1;
            exp_value = ref_pc + {word[31:12], 12'b0};
        end
        opc_op_imm: begin
            exp_wb    = 1'b1;
            exp_value = arith_result(f3, 1'b0, a, imm_i);
        end
        opc_op: begin
            exp_wb    = 1'b1;
            exp_value = arith_result(f3, word[30], a, b);
        end
        opc_load, opc_store: begin
            exp_mem  = 1'b1;
            exp_we   = (word[6:0] == opc_store);
            exp_addr = a + (exp_we ? imm_s : imm_i);
            if (exp_addr < data_base || exp_addr >= data_base + 32'd1024
                    || exp_addr[1:0] != 2'b00) begin
                stop_with_failure("generated program addressed outside the data window");
            end
            if (exp_we) begin
                exp_store = b;
                ref_mem[word_index(exp_addr)] = b;
            end else begin
                exp_wb    = 1'b1;
                exp_value = ref_mem[word_index(exp_addr)];
            end
        end
        opc_branch: begin
            taken = (f3 == 3'b000) ? (a == b) : (a != b);
            if (f3 == 3'b000) begin
                beq_taken += taken ? 1 : 0;
                beq_fall  += taken ? 0 : 1;
            end else begin
                bne_taken += taken ? 1 : 0;
                bne_fall  += taken ? 0 : 1;
            end
        end
        default: begin
            stop_with_failure("reference model met an opcode outside the subset");
        end
    endcase
    if (exp_wb && rd != 5'd0) begin
        ref_regs[rd] = exp_value;
    end
    ref_pc = (word[6:0] == opc_branch && taken) ? ref_pc + imm_b : ref_pc + 32'd4;
endtask

`endif

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ns

module rv_core_tb;

    localparam int          clk_period   = 4;
    localparam int          reset_cycles = 16;
    localparam int          num_instr    = 200;  // random program length, the loop follows it
    localparam int          watchdog_ns  = (num_instr * 5 * 2 + reset_cycles) * clk_period;
    localparam logic [31:0] data_base    = 32'h0000_2000;  // first of 256 data words
    localparam logic [31:0] loop_addr    = 32'(num_instr * 4);
    localparam logic [6:0]  opc_lui      = 7'b0110111;
    localparam logic [6:0]  opc_auipc    = 7'b0010111;
    localparam logic [6:0]  opc_op_imm   = 7'b0010011;
    localparam logic [6:0]  opc_op       = 7'b0110011;
    localparam logic [6:0]  opc_load     = 7'b0000011;
    localparam logic [6:0]  opc_store    = 7'b0100011;
    localparam logic [6:0]  opc_branch   = 7'b1100011;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        instr_req;
    logic [31:0] instr_addr;
    logic [31:0] instr_data;
    logic        data_req;
    logic        data_we;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    int          x0_writes   = 0;

    rv_core_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_req  (instr_req),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .data_req   (data_req),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("ERROR: %s", reason);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %08h, actual %08h", name, expected, actual);
            stop_with_failure("value check failed");
        end
    endtask

    function automatic logic [7:0] word_index(input logic [31:0] addr);
        return 8'((addr - data_base) >> 2);
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]};  // every address bit matters
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic logic [2:0] alu_funct3();
        case ($urandom_range(0, 4))
            0:       return 3'b000;
            1:       return 3'b010;
            2:       return 3'b100;
            3:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    `include "iss_model.svh"

    task automatic build_program();
        bit          jump_ok [num_instr + 1];  // no branch may land inside a lui/addi/lw group
        int          branches [$];
        int          idx;
        int          t;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] off;
        logic [31:0] w;
        foreach (imem[i]) begin
            imem[i] = b_word(13'd0, 5'd0, 5'd0, 3'b000);  // beq x0,x0,0 everywhere else
        end
        foreach (jump_ok[i]) begin
            jump_ok[i] = 1'b1;
        end
        for (int r = 1; r < 31; r++) begin
            imem[r - 1] = i_word(12'($urandom), 5'd0, 3'b000, 5'(r), opc_op_imm);
        end
        imem[30] = {20'h00002, 5'd31, opc_lui};
        imem[31] = i_word(12'h07b, 5'd1, 3'b000, 5'd0, opc_op_imm);  // a write to x0
        imem[32] = {7'b0, 5'd2, 5'd0, 3'b000, 5'd3, opc_op};         // then a read of it
        idx = 33;
        while (idx < num_instr) begin
            rd  = 5'($urandom_range(0, 30));
            rs1 = 5'($urandom_range(0, 30));
            rs2 = ($urandom_range(0, 1) == 0) ? rs1 : 5'($urandom_range(0, 30));
            f3  = alu_funct3();
            off = 12'(4 * $urandom_range(0, 127));
            case ($urandom_range(0, 9))
                0:    w = {20'($urandom), rd, opc_lui};
                1:    w = {20'($urandom), rd, opc_auipc};
                2, 3: w = i_word(12'($urandom), rs1, f3, rd, opc_op_imm);
                4, 5: begin
                    w = {(f3 == 3'b000 && $urandom_range(0, 1) == 1) ? 7'b0100000 : 7'b0,
                         rs2, rs1, f3, rd, opc_op};
                end
                6, 7: begin
                    w = b_word(13'd0, rs1, rs2, {2'b00, 1'($urandom)});  // offset set below
                    branches.push_back(idx);
                end
                default: begin
                    if (idx + 3 <= num_instr) begin
                        imem[idx]     = {20'h00002, 5'd31, opc_lui};
                        imem[idx + 1] = i_word(12'(4 * $urandom_range(0, 127)), 5'd31, 3'b000,
                                               5'd31, opc_op_imm);
                        jump_ok[idx + 1] = 1'b0;
                        jump_ok[idx + 2] = 1'b0;
                        idx += 2;
                        if ($urandom_range(0, 1) == 0) begin
                            w = i_word(off, 5'd31, 3'b010, rd, opc_load);
                        end else begin
                            w = {off[11:5], rs2, 5'd31, 3'b010, off[4:0], opc_store};
                        end
                    end else begin
                        w = i_word(12'($urandom), rs1, 3'b000, rd, opc_op_imm);
                    end
                end
            endcase
            imem[idx] = w;
            idx++;
        end
        foreach (branches[n]) begin
            t = branches[n] + $urandom_range(1, 8);
            if (t > num_instr) begin
                t = num_instr;
            end
            while (!jump_ok[t]) begin
                t++;
            end
            w = imem[branches[n]];
            imem[branches[n]] = b_word(13'((t - branches[n]) * 4), w[19:15], w[24:20], w[14:12]);
        end
    endtask

    initial begin
        #(watchdog_ns);
        stop_with_failure("watchdog expired before the program reached its final loop");
    end

    initial begin
        logic [31:0] fetch_word;
        logic [31:0] read_word;
        logic        fetch_seen;
        logic        read_seen;
        logic        done;
        int          cycle_gap;
        int          expected_gap;
        int          fetches;
        void'($urandom(32'hae3d166c));
        rst_n        = 1'b0;
        instr_data   = '0;
        data_rdata   = '0;
        fetch_word   = '0;
        read_word    = '0;
        done         = 1'b0;
        cycle_gap    = 0;
        expected_gap = 4;
        fetches      = 0;
        build_program();
        foreach (dmem[i]) begin
            dmem[i]    = fill_word(data_base + 32'(i * 4));
            ref_mem[i] = fill_word(data_base + 32'(i * 4));
        end
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        ref_pc = 32'h0;  // first fetch after reset
        repeat (reset_cycles) begin
            @(negedge clk);
            check_equal("strobes in reset", 32'h0, 32'({instr_req, data_req, data_we, wb_valid}));
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_equal("strobes after reset", 32'h0, 32'({instr_req, data_req, data_we, wb_valid}));
        while (!done) begin
            fetch_seen = 1'b0;
            read_seen  = 1'b0;
            if (wb_valid) begin
                if (!exp_wb) begin
                    stop_with_failure("register write traced where the model expects none");
                end
                check_equal("writeback rd", 32'(exp_rd), 32'(wb_rd));
                check_equal("writeback data", exp_value, wb_data);
                x0_writes += (wb_rd == 5'd0) ? 1 : 0;
                exp_wb = 1'b0;
            end
            if (data_req) begin
                if (!exp_mem) begin
                    stop_with_failure("data request where the model expects none");
                end
                check_equal("data write flag", 32'(exp_we), 32'(data_we));
                check_equal("data address", exp_addr, data_addr);
                if (data_we) begin
                    check_equal("store data", exp_store, data_wdata);
                    dmem[word_index(data_addr)] = data_wdata;
                end else begin
                    read_word = dmem[word_index(data_addr)];
                    read_seen = 1'b1;
                end
                exp_mem = 1'b0;
            end
            if (instr_req) begin
                if (exp_wb || exp_mem) begin
                    stop_with_failure("an instruction ended without its writeback or data access");
                end
                if (fetches > 0) begin
                    check_equal("fetch spacing", 32'(expected_gap), 32'(cycle_gap));
                end
                check_equal("fetch address", ref_pc, instr_addr);
                cycle_gap  = 0;
                fetches++;
                fetch_word = imem[instr_addr[9:2]];
                fetch_seen = 1'b1;
                if (instr_addr == loop_addr) begin
                    done = 1'b1;
                end else begin
                    step_reference(fetch_word);
                    expected_gap = exp_mem ? 5 : 4;  // lw and sw pass through the memory state
                end
            end
            @(posedge clk);
            #1;
            instr_data = fetch_seen ? fetch_word : '0;
            data_rdata = read_seen ? read_word : '0;
            @(negedge clk);
            cycle_gap++;
        end
        $display("fetches %0d, beq %0d/%0d, bne %0d/%0d taken/not taken, x0 writes %0d",
                 fetches, beq_taken, beq_fall, bne_taken, bne_fall, x0_writes);
        if (beq_taken == 0 || beq_fall == 0 || bne_taken == 0 || bne_fall == 0) begin
            stop_with_failure("the program did not run taken and not-taken beq and bne");
        end else if (x0_writes == 0) begin
            stop_with_failure("no write to x0 appeared on the trace");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== rv_core_top.f ====
+incdir+bench
design/rv_core_pkg.sv
design/main_controller.sv
design/core_sequencer.sv
design/program_counter.sv
design/register_bank.sv
design/immediate_gen.sv
design/alu.sv
design/rv_core_top.sv
bench/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compiles the core with its testbench in Verilator and runs the simulation
set -e

cd "$(dirname "$0")"

build_dir=build
log_file="$build_dir/sim.log"

mkdir -p "$build_dir"

verilator --binary --timing --assert \
    -f rv_core_top.f \
    --top-module rv_core_tb \
    -Mdir "$build_dir/obj" \
    -o rv_core_sim

"$build_dir/obj/rv_core_sim" > "$log_file" 2>&1 || true
cat "$log_file"

if grep -qx "Test passed" "$log_file"; then
    echo "simulation result: pass"
else
    echo "simulation result: fail, see $log_file"
    exit 1
fi
